// File: tb.f
rtl/lcd_spi_pkg.sv
rtl/st7735_cmd_pkg.sv
rtl/lcd_xfer_if.sv
rtl/spi_serializer.sv
rtl/init_sequencer.sv
rtl/host_port.sv
rtl/st7735_ctrl.sv
test/panel_model.sv
test/tb_st7735.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_st7735
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_st7735.sv
`timescale 1ns/1ps

module tb_st7735;

   localparam int num_writes   = 40;
   localparam int rst_timeout  = 400;
   localparam int init_timeout = 6000;
   localparam int xfer_timeout = 200;

   logic        clk;
   logic        rst_n;
   logic        wstrb;
   logic        sel_cmd;
   logic        sel_dat;
   logic        sel_dat16;
   logic [15:0] wdata;
   logic        busy;
   logic        oled_mosi;
   logic        oled_clk;
   logic        oled_cs;
   logic        oled_dc;
   logic        oled_rst;

   int          rx_count;
   logic [15:0] rx_data;
   int          rx_bits;
   logic        rx_dc;
   int          rst_low_bits;

   // words the panel should see, oldest first
   lcd_spi_pkg::xfer_word_t exp_q[$];

   int seen_count   = 0;
   int errors       = 0;
   int checks       = 0;
   int frame_errs   = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int accepted     = 0;
   int ignored      = 0;
   bit timed_out    = 1'b0;

   st7735_ctrl uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .wstrb     (wstrb),
      .sel_cmd   (sel_cmd),
      .sel_dat   (sel_dat),
      .sel_dat16 (sel_dat16),
      .wdata     (wdata),
      .busy      (busy),
      .oled_mosi (oled_mosi),
      .oled_clk  (oled_clk),
      .oled_cs   (oled_cs),
      .oled_dc   (oled_dc),
      .oled_rst  (oled_rst)
   );

   panel_model panel (
      .oled_mosi    (oled_mosi),
      .oled_clk     (oled_clk),
      .oled_cs      (oled_cs),
      .oled_dc      (oled_dc),
      .oled_rst     (oled_rst),
      .rx_count     (rx_count),
      .rx_data      (rx_data),
      .rx_bits      (rx_bits),
      .rx_dc        (rx_dc),
      .rst_low_bits (rst_low_bits)
   );

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // table entry as the panel should receive it
   function automatic lcd_spi_pkg::xfer_word_t entry_word(st7735_cmd_pkg::init_entry_t e);
      lcd_spi_pkg::xfer_word_t w;
      w.payload = {8'h00, e.value};
      if (e.is_param) begin
         w.kind = lcd_spi_pkg::kind_dat8;
      end else begin
         w.kind = lcd_spi_pkg::kind_cmd8;
      end
      return w;
   endfunction

   // kind 0 command, 1 data byte, 2 pixel word
   function automatic lcd_spi_pkg::xfer_word_t expected_host_word(int kind, logic [15:0] data);
      lcd_spi_pkg::xfer_word_t w;
      w.payload = {8'h00, data[7:0]};
      if (kind == 2) begin
         w.kind    = lcd_spi_pkg::kind_dat16;
         w.payload = data;
      end else if (kind == 0) begin
         w.kind = lcd_spi_pkg::kind_cmd8;
      end else begin
         w.kind = lcd_spi_pkg::kind_dat8;
      end
      return w;
   endfunction

   task automatic compare_word(input string name, input lcd_spi_pkg::xfer_word_t got,
                               input lcd_spi_pkg::xfer_word_t want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("error at %0t ns: %s got kind %0d payload %h, expected kind %0d payload %h",
                  $time, name, got.kind, got.payload, want.kind, want.payload);
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("error at %0t ns: %s got %b expected %b", $time, name, got, want);
      end
   endtask

   task automatic report_test(input string name, input int errs);
      tests_run++;
      if (errs == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errs);
      end
   endtask

   task automatic check_cs_idle();
      if (oled_cs !== 1'b1) begin
         frame_errs++;
      end
      compare_bit("oled_cs", oled_cs, 1'b1);
   endtask

   task automatic wait_busy_low(input int limit, input string what);
      int n;
      n = 0;
      // busy settles after a strobe taken on the last rising edge
      @(negedge clk);
      while (busy !== 1'b0 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (busy !== 1'b0) begin
         $display("timeout after %0d cycles waiting for %s", limit, what);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_rst_high(input int limit);
      int n;
      n = 0;
      while (oled_rst !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (oled_rst !== 1'b1) begin
         $display("timeout after %0d cycles waiting for the panel reset release", limit);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   // monitor checks words on negedge, let it catch up
   task automatic wait_monitor_sync(input int limit);
      int n;
      n = 0;
      while (seen_count != rx_count && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (seen_count != rx_count) begin
         $display("timeout waiting for the word checker to catch up");
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic check_rx_word();
      lcd_spi_pkg::xfer_word_t got;
      lcd_spi_pkg::xfer_word_t want;
      int                      want_bits;
      if (exp_q.size() == 0) begin
         $display("word %h of %0d bits arrived with nothing expected", rx_data, rx_bits);
         errors++;
         return;
      end
      want      = exp_q.pop_front();
      want_bits = (want.kind == lcd_spi_pkg::kind_dat16) ? 16 : 8;
      if (rx_bits != want_bits) begin
         $display("word %0d framed by %0d serial clock edges instead of %0d",
                  seen_count, rx_bits, want_bits);
         errors++;
         frame_errs++;
      end
      // width decides pixel word, dc splits the bytes
      got.payload = (rx_bits == 16) ? rx_data : {8'h00, rx_data[7:0]};
      if (rx_bits == 16) begin
         got.kind = lcd_spi_pkg::kind_dat16;
      end else if (rx_dc) begin
         got.kind = lcd_spi_pkg::kind_dat8;
      end else begin
         got.kind = lcd_spi_pkg::kind_cmd8;
      end
      compare_word("rx_word", got, want);
      compare_bit("oled_dc", rx_dc, want.kind != lcd_spi_pkg::kind_cmd8);
   endtask

   // words checked as the panel closes them
   initial begin
      forever begin
         @(negedge clk);
         if (rx_count != seen_count) begin
            seen_count++;
            check_rx_word();
         end
      end
   end

   task automatic strobe_while_busy(input int n);
      int j;
      for (j = 0; j < n; j++) begin
         @(posedge clk);
         wstrb   <= 1'b1;
         sel_cmd <= 1'b1;
         wdata   <= 16'($urandom);
         @(negedge clk);
         // strobe is sampled on the coming edge
         compare_bit("busy", busy, 1'b1);
         @(posedge clk);
         wstrb   <= 1'b0;
         sel_cmd <= 1'b0;
         ignored++;
      end
   endtask

   task automatic host_write(input int kind, input logic [15:0] data, input bit extra);
      @(posedge clk);
      wstrb     <= 1'b1;
      sel_cmd   <= (kind == 0);
      sel_dat   <= (kind == 1);
      sel_dat16 <= (kind == 2);
      wdata     <= data;
      @(posedge clk);
      // held strobe lands on a busy port
      if (extra) begin
         wdata <= ~data;
         ignored++;
         @(posedge clk);
      end
      wstrb     <= 1'b0;
      sel_cmd   <= 1'b0;
      sel_dat   <= 1'b0;
      sel_dat16 <= 1'b0;
   endtask

   task automatic run_tests();
      int          i;
      int          gap;
      int          kind;
      int          errs_before;
      int          idle_low;
      logic [15:0] data;
      bit          extra;

      // pins straight after reset
      errs_before = errors;
      @(negedge clk);
      compare_bit("oled_cs", oled_cs, 1'b1);
      compare_bit("oled_rst", oled_rst, 1'b0);
      compare_bit("oled_dc", oled_dc, 1'b0);
      compare_bit("busy", busy, 1'b1);
      wait_rst_high(rst_timeout);
      if (timed_out) begin
         return;
      end
      if (rx_count != 0 || rst_low_bits != 0) begin
         $display("serial traffic seen while oled_rst was low");
         errors++;
      end
      report_test("reset idle state", errors - errs_before);

      // host strobes during init must vanish
      strobe_while_busy(3);

      errs_before = errors;
      wait_busy_low(init_timeout, "init table playback");
      if (timed_out) begin
         return;
      end
      if (rx_count != st7735_cmd_pkg::init_len) begin
         $display("busy fell after %0d words instead of %0d", rx_count,
                  st7735_cmd_pkg::init_len);
         errors++;
      end
      wait_monitor_sync(xfer_timeout);
      if (timed_out) begin
         return;
      end
      report_test("init playback", errors - errs_before);

      errs_before = errors;
      for (i = 0; i < num_writes; i++) begin
         wait_busy_low(xfer_timeout, "host write to finish");
         if (timed_out) begin
            return;
         end
         check_cs_idle();
         gap   = $urandom_range(4, 0);
         kind  = $urandom_range(2, 0);
         data  = 16'($urandom);
         extra = ($urandom_range(1, 0) == 1);
         exp_q.push_back(expected_host_word(kind, data));
         repeat (gap) @(posedge clk);
         host_write(kind, data, extra);
         accepted++;
      end
      wait_busy_low(xfer_timeout, "last host write to finish");
      if (timed_out) begin
         return;
      end
      wait_monitor_sync(xfer_timeout);
      if (timed_out) begin
         return;
      end
      report_test("host writes", errors - errs_before);

      // every ignored strobe would show up as an extra word
      errs_before = errors;
      if (rx_count != st7735_cmd_pkg::init_len + accepted) begin
         $display("panel received %0d words, expected %0d", rx_count,
                  st7735_cmd_pkg::init_len + accepted);
         errors++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected words never arrived", exp_q.size());
         errors++;
      end
      report_test("strobes while busy", errors - errs_before);

      // link idle, cs must stay high
      idle_low = 0;
      for (i = 0; i < 32; i++) begin
         @(negedge clk);
         if (oled_cs !== 1'b1) begin
            idle_low++;
         end
      end
      if (idle_low != 0) begin
         $display("oled_cs low for %0d cycles with no transfer", idle_low);
         errors++;
         frame_errs++;
      end
      if (rst_low_bits != 0) begin
         $display("%0d bits clocked while the panel was in reset", rst_low_bits);
         errors++;
         frame_errs++;
      end
      report_test("chip-select framing", frame_errs);
   endtask

   task automatic finish_run();
      $display("tests %0d, failed %0d, checks %0d, errors %0d, writes %0d, ignored strobes %0d",
               tests_run, tests_failed, checks, errors, accepted, ignored);
      if (errors == 0 && !timed_out && tests_failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   initial begin
      int k;
      rst_n     = 1'b0;
      wstrb     = 1'b0;
      sel_cmd   = 1'b0;
      sel_dat   = 1'b0;
      sel_dat16 = 1'b0;
      wdata     = '0;
      void'($urandom(93));
      // init words come first, in table order
      for (k = 0; k < st7735_cmd_pkg::init_len; k++) begin
         exp_q.push_back(entry_word(st7735_cmd_pkg::init_table[k]));
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      run_tests();
      finish_run();
   end

endmodule

// File: test/panel_model.sv
`timescale 1ns/1ps

// receive side of the st7735 link
// mosi sampled on rising oled_clk while cs is low
// a word closes when cs goes back high
module panel_model (
   input  logic        oled_mosi,
   input  logic        oled_clk,
   input  logic        oled_cs,
   input  logic        oled_dc,
   input  logic        oled_rst,
   output int          rx_count,
   output logic [15:0] rx_data,
   output int          rx_bits,
   output logic        rx_dc,
   output int          rst_low_bits
);

   // running bit total, a frame is the difference since the last cs rise
   int          total_bits  = 0;
   int          frame_start = 0;
   int          count_q     = 0;
   int          rst_low_q   = 0;
   int          bits_q      = 0;
   logic [15:0] shift_q     = '0;
   logic [15:0] data_q      = '0;
   logic        dc_q        = 1'b0;
   logic        dc_word_q   = 1'b0;

   assign rx_count     = count_q;
   assign rx_data      = data_q;
   assign rx_bits      = bits_q;
   assign rx_dc        = dc_word_q;
   assign rst_low_bits = rst_low_q;

   always @(posedge oled_clk) begin
      if (oled_cs === 1'b0) begin
         // msb arrives first, so shift in from the right
         shift_q    = {shift_q[14:0], oled_mosi};
         dc_q       = oled_dc;
         total_bits = total_bits + 1;
         // panel held in reset must not see traffic
         if (oled_rst !== 1'b1) begin
            rst_low_q = rst_low_q + 1;
         end
      end
   end

   always @(posedge oled_cs) begin
      // cs rising with no bits is not a word
      if (total_bits != frame_start) begin
         data_q      = shift_q;
         bits_q      = total_bits - frame_start;
         dc_word_q   = dc_q;
         frame_start = total_bits;
         count_q     = count_q + 1;
      end
   end

endmodule

// File: rtl/st7735_ctrl.sv
`timescale 1ns/1ps

module st7735_ctrl (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wstrb,
   input  logic        sel_cmd,
   input  logic        sel_dat,
   input  logic        sel_dat16,
   input  logic [15:0] wdata,
   output logic        busy,
   output logic        oled_mosi,
   output logic        oled_clk,
   output logic        oled_cs,
   output logic        oled_dc,
   output logic        oled_rst
);

   logic init_done;

   // sequencer to host port
   lcd_xfer_if init_link ();
   // host port to serializer
   lcd_xfer_if spi_link ();

   init_sequencer u_init (
      .clk      (clk),
      .rst_n    (rst_n),
      .xfer     (init_link.source),
      .oled_rst (oled_rst),
      .done     (init_done)
   );

   host_port u_host (
      .clk       (clk),
      .rst_n     (rst_n),
      .wstrb     (wstrb),
      .sel_cmd   (sel_cmd),
      .sel_dat   (sel_dat),
      .sel_dat16 (sel_dat16),
      .wdata     (wdata),
      .init_done (init_done),
      .init_xfer (init_link.sink),
      .out_xfer  (spi_link.source),
      .busy      (busy)
   );

   spi_serializer u_spi (
      .clk       (clk),
      .rst_n     (rst_n),
      .xfer      (spi_link.sink),
      .oled_mosi (oled_mosi),
      .oled_clk  (oled_clk),
      .oled_cs   (oled_cs),
      .oled_dc   (oled_dc)
   );

endmodule

// File: rtl/host_port.sv
`timescale 1ns/1ps

module host_port (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wstrb,
   input  logic        sel_cmd,
   input  logic        sel_dat,
   input  logic        sel_dat16,
   input  logic [15:0] wdata,
   input  logic        init_done,
   lcd_xfer_if.sink    init_xfer,
   lcd_xfer_if.source  out_xfer,
   output logic        busy
);

   typedef enum logic [1:0] {
      h_idle,
      h_load,
      h_wait_ack,
      h_wait_low
   } host_state_t;

   host_state_t             state;
   lcd_spi_pkg::xfer_word_t host_word;
   logic                    host_req;
   logic                    host_active;
   logic                    accept;

   assign host_active = (state != h_idle);
   assign busy = !init_done || host_active;

   // exactly one destination per strobe
   assign accept = wstrb && !busy &&
                   ({sel_cmd, sel_dat, sel_dat16} inside {3'b100, 3'b010, 3'b001});

   // init traffic owns the link until done
   assign out_xfer.req  = init_done ? host_req  : init_xfer.req;
   assign out_xfer.word = init_done ? host_word : init_xfer.word;
   assign init_xfer.ack = init_done ? 1'b0      : out_xfer.ack;

   always_ff @(posedge clk) begin
      if (accept) begin
         if (sel_dat16) begin
            host_word.kind    <= lcd_spi_pkg::kind_dat16;
            host_word.payload <= wdata;
         end else begin
            host_word.kind    <= sel_cmd ? lcd_spi_pkg::kind_cmd8 : lcd_spi_pkg::kind_dat8;
            host_word.payload <= {8'h00, wdata[7:0]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= h_idle;
         host_req <= 1'b0;
      end else begin
         case (state)
            h_idle: begin
               if (accept) begin
                  state <= h_load;
               end
            end
            // word captured, raise req
            h_load: begin
               host_req <= 1'b1;
               state    <= h_wait_ack;
            end
            h_wait_ack: begin
               if (out_xfer.ack) begin
                  host_req <= 1'b0;
                  state    <= h_wait_low;
               end
            end
            default: begin
               if (!out_xfer.ack) begin
                  state <= h_idle;
               end
            end
         endcase
      end
   end

   // host names at most one destination on a strobe the port can take
   a_one_sel: assert property (
      @(posedge clk) disable iff (!rst_n)
      (wstrb && !busy) |-> $onehot0({sel_cmd, sel_dat, sel_dat16})
   );

endmodule

// File: rtl/init_sequencer.sv
`timescale 1ns/1ps

module init_sequencer (
   input  logic        clk,
   input  logic        rst_n,
   lcd_xfer_if.source  xfer,
   output logic        oled_rst,
   output logic        done
);

   typedef enum logic [2:0] {
      st_rst_low,
      st_rst_wait,
      st_issue,
      st_wait_ack,
      st_release,
      st_delay,
      st_done
   } seq_state_t;

   seq_state_t                                  state;
   logic [$clog2(st7735_cmd_pkg::init_len)-1:0] idx;
   st7735_cmd_pkg::delay_cnt_t                  cnt;
   st7735_cmd_pkg::init_entry_t                 entry;

   // settle count after an entry, counted down to zero
   function automatic st7735_cmd_pkg::delay_cnt_t delay_len(
      st7735_cmd_pkg::delay_sel_t sel
   );
      case (sel)
         st7735_cmd_pkg::dsel_short:
            delay_len = st7735_cmd_pkg::delay_cnt_t'(st7735_cmd_pkg::delay_short - 1);
         st7735_cmd_pkg::dsel_medium:
            delay_len = st7735_cmd_pkg::delay_cnt_t'(st7735_cmd_pkg::delay_medium - 1);
         st7735_cmd_pkg::dsel_long:
            delay_len = st7735_cmd_pkg::delay_cnt_t'(st7735_cmd_pkg::delay_long - 1);
         default:
            delay_len = '0;
      endcase
   endfunction

   assign entry = st7735_cmd_pkg::init_table[idx];

   // request word, held stable through the handshake
   always_ff @(posedge clk) begin
      if (state == st_issue) begin
         xfer.word.payload <= {8'h00, entry.value};
         if (entry.is_param) begin
            xfer.word.kind <= lcd_spi_pkg::kind_dat8;
         end else begin
            xfer.word.kind <= lcd_spi_pkg::kind_cmd8;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= st_rst_low;
         idx      <= '0;
         cnt      <= '0;
         oled_rst <= 1'b0;
         done     <= 1'b0;
         xfer.req <= 1'b0;
      end else begin
         case (state)
            // panel held in reset
            st_rst_low: begin
               if (cnt == st7735_cmd_pkg::delay_cnt_t'(st7735_cmd_pkg::reset_low_cycles - 1)) begin
                  oled_rst <= 1'b1;
                  cnt      <= '0;
                  state    <= st_rst_wait;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            // panel boots after release
            st_rst_wait: begin
               if (cnt == st7735_cmd_pkg::delay_cnt_t'(st7735_cmd_pkg::reset_wait_cycles - 1)) begin
                  idx   <= '0;
                  state <= st_issue;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            st_issue: begin
               xfer.req <= 1'b1;
               state    <= st_wait_ack;
            end
            st_wait_ack: begin
               if (xfer.ack) begin
                  xfer.req <= 1'b0;
                  state    <= st_release;
               end
            end
            // wait for ack low before the delay starts
            st_release: begin
               if (!xfer.ack) begin
                  cnt   <= delay_len(entry.delay);
                  state <= st_delay;
               end
            end
            st_delay: begin
               if (cnt == '0) begin
                  if (int'(idx) == st7735_cmd_pkg::init_len - 1) begin
                     done  <= 1'b1;
                     state <= st_done;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= st_issue;
                  end
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            // table played, hold here
            default: begin
               state <= st_done;
            end
         endcase
      end
   end

   a_idx_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_issue) |-> (int'(idx) < st7735_cmd_pkg::init_len)
   );

endmodule

// File: rtl/spi_serializer.sv
`timescale 1ns/1ps

module spi_serializer (
   input  logic       clk,
   input  logic       rst_n,
   lcd_xfer_if.sink   xfer,
   output logic       oled_mosi,
   output logic       oled_clk,
   output logic       oled_cs,
   output logic       oled_dc
);

   localparam int msb = lcd_spi_pkg::word_max_bits - 1;

   logic [lcd_spi_pkg::spi_div_log2-1:0] div_cnt;
   logic                                 tick;
   logic [msb:0]                         shifter;
   lcd_spi_pkg::bit_count_t              bit_cnt;
   logic                                 active;
   logic                                 load;

   // divider msb is the serial clock
   assign oled_clk = div_cnt[lcd_spi_pkg::spi_div_log2-1];
   // all ones, so oled_clk falls on the next edge
   assign tick = &div_cnt;

   assign active = (bit_cnt != '0);
   // new word only once the previous handshake is closed
   assign load = xfer.req && !xfer.ack && !active;

   // msb first
   assign oled_mosi = shifter[msb];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         // byte kinds go to the upper half
         if (xfer.word.kind == lcd_spi_pkg::kind_dat16) begin
            shifter <= xfer.word.payload;
         end else begin
            shifter <= {xfer.word.payload[7:0], 8'h00};
         end
      end else if (tick && active && !oled_cs) begin
         shifter <= {shifter[msb-1:0], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_cnt  <= '0;
         oled_cs  <= 1'b1;
         oled_dc  <= 1'b0;
         xfer.ack <= 1'b0;
      end else begin
         // return to zero once the source lets go
         if (xfer.ack && !xfer.req) begin
            xfer.ack <= 1'b0;
         end
         if (load) begin
            oled_cs <= 1'b1;
            oled_dc <= (xfer.word.kind != lcd_spi_pkg::kind_cmd8);
            if (xfer.word.kind == lcd_spi_pkg::kind_dat16) begin
               bit_cnt <= lcd_spi_pkg::bit_count_t'(lcd_spi_pkg::word_max_bits);
            end else begin
               bit_cnt <= lcd_spi_pkg::bit_count_t'(8);
            end
         end else if (tick && active) begin
            if (oled_cs) begin
               // first tick only opens the frame
               oled_cs <= 1'b0;
            end else begin
               bit_cnt <= bit_cnt - 1'b1;
               // last bit sampled, close frame and ack
               if (bit_cnt == lcd_spi_pkg::bit_count_t'(1)) begin
                  oled_cs  <= 1'b1;
                  xfer.ack <= 1'b1;
               end
            end
         end
      end
   end

   // ack only comes up while the source still holds req
   a_ack_in_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(xfer.ack) |-> xfer.req
   );

   a_cnt_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      bit_cnt <= lcd_spi_pkg::bit_count_t'(lcd_spi_pkg::word_max_bits)
   );

endmodule

// File: rtl/lcd_xfer_if.sv
`timescale 1ns/1ps

// four-phase word handshake
// source raises req with word stable, sink acks after the last bit
// source drops req, sink drops ack one clk later
interface lcd_xfer_if;

   logic                    req;
   lcd_spi_pkg::xfer_word_t word;
   logic                    ack;

   modport source (
      output req,
      output word,
      input  ack
   );

   modport sink (
      input  req,
      input  word,
      output ack
   );

endinterface

// File: rtl/st7735_cmd_pkg.sv
package st7735_cmd_pkg;

   // st7735 opcodes used during power-up
   localparam logic [7:0] cmd_swreset = 8'h01;
   localparam logic [7:0] cmd_slpout  = 8'h11;
   localparam logic [7:0] cmd_invctr  = 8'hb4;
   localparam logic [7:0] cmd_pwctr1  = 8'hc0;
   localparam logic [7:0] cmd_pwctr4  = 8'hc3;
   localparam logic [7:0] cmd_pwctr5  = 8'hc4;
   localparam logic [7:0] cmd_vmctr1  = 8'hc5;
   localparam logic [7:0] cmd_invon   = 8'h21;
   localparam logic [7:0] cmd_madctl  = 8'h36;
   localparam logic [7:0] cmd_colmod  = 8'h3a;
   localparam logic [7:0] cmd_caset   = 8'h2a;
   localparam logic [7:0] cmd_raset   = 8'h2b;
   localparam logic [7:0] cmd_noron   = 8'h13;
   localparam logic [7:0] cmd_dispon  = 8'h29;

   // settle delay after an entry
   typedef enum logic [1:0] {
      dsel_none   = 2'd0,
      dsel_short  = 2'd1,
      dsel_medium = 2'd2,
      dsel_long   = 2'd3
   } delay_sel_t;

   typedef struct packed {
      logic [7:0] value;
      logic       is_param;
      delay_sel_t delay;
   } init_entry_t;

   // panel reset pin timing, in clk cycles
   localparam int reset_low_cycles  = 64;
   localparam int reset_wait_cycles = 128;

   // settle delays, scaled down for simulation
   localparam int delay_short  = 40;
   localparam int delay_medium = 100;
   localparam int delay_long   = 200;

   typedef logic [7:0] delay_cnt_t;

   localparam int init_len = 33;

   // power-up sequence, params go out as data bytes
   localparam init_entry_t init_table [init_len] = '{
      '{cmd_swreset, 1'b0, dsel_medium},
      '{cmd_slpout,  1'b0, dsel_long},
      '{cmd_invctr,  1'b0, dsel_none},
      '{8'h07,       1'b1, dsel_none},
      '{cmd_pwctr1,  1'b0, dsel_none},
      '{8'ha2,       1'b1, dsel_none},
      '{8'h02,       1'b1, dsel_none},
      '{8'h84,       1'b1, dsel_none},
      '{cmd_pwctr4,  1'b0, dsel_none},
      '{8'h8a,       1'b1, dsel_none},
      '{8'h2a,       1'b1, dsel_none},
      '{cmd_pwctr5,  1'b0, dsel_none},
      '{8'h8a,       1'b1, dsel_none},
      '{8'hee,       1'b1, dsel_none},
      '{cmd_vmctr1,  1'b0, dsel_none},
      '{8'h0e,       1'b1, dsel_none},
      '{cmd_invon,   1'b0, dsel_none},
      '{cmd_madctl,  1'b0, dsel_none},
      '{8'hc8,       1'b1, dsel_none},
      '{cmd_colmod,  1'b0, dsel_none},
      '{8'h05,       1'b1, dsel_none},
      '{cmd_caset,   1'b0, dsel_none},
      '{8'h00,       1'b1, dsel_none},
      '{8'h1a,       1'b1, dsel_none},
      '{8'h00,       1'b1, dsel_none},
      '{8'h6a,       1'b1, dsel_none},
      '{cmd_raset,   1'b0, dsel_none},
      '{8'h00,       1'b1, dsel_none},
      '{8'h01,       1'b1, dsel_none},
      '{8'h00,       1'b1, dsel_none},
      '{8'ha1,       1'b1, dsel_none},
      '{cmd_noron,   1'b0, dsel_short},
      '{cmd_dispon,  1'b0, dsel_medium}
   };

endpackage

// File: rtl/lcd_spi_pkg.sv
package lcd_spi_pkg;

   // serial clock is clk / 2**spi_div_log2
   localparam int spi_div_log2 = 1;

   // longest word on the wire, one rgb565 pixel
   localparam int word_max_bits = 16;

   // bits still to shift, 0 means idle
   typedef logic [4:0] bit_count_t;

   // what a word means to the panel
   typedef enum logic [1:0] {
      kind_cmd8  = 2'd0,
      kind_dat8  = 2'd1,
      kind_dat16 = 2'd2
   } word_kind_t;

   // one transfer, 8-bit kinds sit in the low byte of payload
   typedef struct packed {
      word_kind_t  kind;
      logic [15:0] payload;
   } xfer_word_t;

endpackage
